/* filelist.f */
+incdir+verif
hdl/emu_pkg.sv
hdl/chan_pkg.sv
hdl/chunk_sequencer.sv
hdl/bit_history.sv
hdl/step_table_loader.sv
hdl/analog_slice.sv
hdl/analog_core.sv
verif/tb_analog_core.sv

/* hdl/analog_core.sv */
`timescale 1ns/10ps

// emulated receiver front end
// sequencer, bit history, table loader and the adc slices
module analog_core import emu_pkg::*, chan_pkg::*; #(
    parameter int chunk_width = 4,
    parameter int num_chunks  = 4,
    parameter int num_slices  = 4,
    parameter int frame_bits  = 8
) (
    input  logic                        emu_clk,
    input  logic                        emu_rst,
    input  logic [frame_bits-1:0]       rx_bits_i,
    input  logic                        cfg_req_i,
    input  tbl_addr_t                   cfg_addr_i,
    input  coef_t                       cfg_data_i,
    output logic                        cfg_ack_o,
    output logic                        frame_valid_o,
    output logic                        clk_adc_o,
    output logic [num_slices-1:0]       adc_sgn_o,
    output mag_t [num_slices-1:0]       adc_mag_o
);
    localparam int idx_w = $clog2(num_chunks);

    logic [idx_w-1:0]       chunk_idx;
    logic [idx_w-1:0]       chunk_valid;
    logic                   sum_restart;
    logic                   frame_end;
    logic [chunk_width-1:0] chunk;
    logic                   tbl_we;
    tbl_addr_t              tbl_waddr;
    coef_t                  tbl_wdata;

    chunk_sequencer #(
        .chunk_width (chunk_width),
        .num_chunks  (num_chunks),
        .num_slices  (num_slices),
        .frame_bits  (frame_bits)
    ) u_sequencer (
        .emu_clk       (emu_clk),
        .emu_rst       (emu_rst),
        .chunk_idx_o   (chunk_idx),
        .chunk_valid_o (chunk_valid),
        .sum_restart_o (sum_restart),
        .frame_end_o   (frame_end),
        .frame_valid_o (frame_valid_o),
        .clk_adc_o     (clk_adc_o)
    );

    bit_history #(
        .chunk_width (chunk_width),
        .num_chunks  (num_chunks),
        .num_slices  (num_slices),
        .frame_bits  (frame_bits)
    ) u_history (
        .emu_clk     (emu_clk),
        .emu_rst     (emu_rst),
        .rx_bits_i   (rx_bits_i),
        .chunk_idx_i (chunk_idx),
        .frame_end_i (frame_end),
        .chunk_o     (chunk)
    );

    step_table_loader #(
        .chunk_width (chunk_width),
        .num_chunks  (num_chunks),
        .num_slices  (num_slices),
        .frame_bits  (frame_bits)
    ) u_loader (
        .emu_clk     (emu_clk),
        .emu_rst     (emu_rst),
        .cfg_req_i   (cfg_req_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_data_i  (cfg_data_i),
        .cfg_ack_o   (cfg_ack_o),
        .tbl_we_o    (tbl_we),
        .tbl_waddr_o (tbl_waddr),
        .tbl_wdata_o (tbl_wdata)
    );

    // table writes are broadcast, each slice filters on its own index
    for (genvar g = 0; g < num_slices; g++) begin : g_slice
        analog_slice #(
            .chunk_width (chunk_width),
            .num_chunks  (num_chunks),
            .num_slices  (num_slices),
            .frame_bits  (frame_bits),
            .slice_index (g)
        ) u_slice (
            .emu_clk       (emu_clk),
            .emu_rst       (emu_rst),
            .chunk_i       (chunk),
            .chunk_valid_i (chunk_valid),
            .sum_restart_i (sum_restart),
            .frame_end_i   (frame_end),
            .tbl_we_i      (tbl_we),
            .tbl_waddr_i   (tbl_waddr),
            .tbl_wdata_i   (tbl_wdata),
            .adc_sgn_o     (adc_sgn_o[g]),
            .adc_mag_o     (adc_mag_o[g])
        );
    end

endmodule

/* hdl/analog_slice.sv */
`timescale 1ns/10ps

// one time-interleaved adc slice
// sums the table contributions of all chunks and reports sign/magnitude
module analog_slice import emu_pkg::*, chan_pkg::*; #(
    parameter int chunk_width = 4,
    parameter int num_chunks  = 4,
    parameter int num_slices  = 4,
    parameter int frame_bits  = 8,
    parameter int slice_index = 0
) (
    input  logic                          emu_clk,
    input  logic                          emu_rst,
    input  logic [chunk_width-1:0]        chunk_i,
    input  logic [$clog2(num_chunks)-1:0] chunk_valid_i,
    input  logic                          sum_restart_i,
    input  logic                          frame_end_i,
    input  logic                          tbl_we_i,
    input  tbl_addr_t                     tbl_waddr_i,
    input  coef_t                         tbl_wdata_i,
    output logic                          adc_sgn_o,
    output mag_t                          adc_mag_o
);
    localparam int tab_aw = $clog2(num_chunks) + chunk_width;
    localparam int depth  = num_chunks << chunk_width;

    coef_t                  table_q [depth];
    logic [chunk_width-1:0] chunk_q;
    logic [tab_aw-1:0]      rd_addr;
    coef_t                  rd_coef;
    logic                   tbl_hit;
    acc_t                   acc_q;
    logic [acc_width-1:0]   acc_abs;
    mag_t                   mag_sat;

    // keep only writes whose slice field matches this slice
    assign tbl_hit = tbl_we_i &&
                     (tbl_waddr_i[$bits(tbl_addr_t)-1:tab_aw] == slice_index);

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            for (int i = 0; i < depth; i++) begin
                table_q[i] <= '0;
            end
        end else if (tbl_hit) begin
            table_q[tbl_waddr_i[tab_aw-1:0]] <= tbl_wdata_i;
        end
    end

    // chunk is registered here, the index arrives already delayed
    always_ff @(posedge emu_clk) begin
        chunk_q <= chunk_i;
    end

    assign rd_addr = {chunk_valid_i, chunk_q};
    assign rd_coef = table_q[rd_addr];    // entry for chunk k while counter is k+1

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            acc_q <= '0;
        end else if (sum_restart_i) begin
            acc_q <= acc_t'(rd_coef);    // first chunk starts a new sum
        end else if (!frame_end_i) begin
            acc_q <= acc_q + acc_t'(rd_coef);
        end
    end

    // absolute value fits unsigned even for the most negative sum
    assign acc_abs = acc_q[acc_width-1] ? acc_width'(-acc_q) : acc_width'(acc_q);
    assign mag_sat = (acc_abs > acc_width'(mag_max)) ? mag_t'(mag_max) : mag_t'(acc_abs);

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            adc_sgn_o <= 1'b0;
            adc_mag_o <= '0;
        end else if (frame_end_i) begin
            adc_sgn_o <= !acc_q[acc_width-1];    // 1 for a non-negative sum
            adc_mag_o <= mag_sat;
        end
    end

    // table updates must not land on the output sampling edge
    no_write_at_frame_end: assert property (
        @(posedge emu_clk) disable iff (emu_rst)
        tbl_hit |-> !frame_end_i
    ) else $error("slice %0d table written at frame end", slice_index);

endmodule

/* hdl/bit_history.sv */
`timescale 1ns/10ps

// received bit history and chunk selector
module bit_history #(
    parameter int chunk_width = 4,
    parameter int num_chunks  = 4,
    parameter int num_slices  = 4,
    parameter int frame_bits  = 8
) (
    input  logic                          emu_clk,
    input  logic                          emu_rst,
    input  logic [frame_bits-1:0]         rx_bits_i,
    input  logic [$clog2(num_chunks)-1:0] chunk_idx_i,
    input  logic                          frame_end_i,
    output logic [chunk_width-1:0]        chunk_o
);
    localparam int hist_w  = num_chunks * chunk_width;
    localparam int shift_w = $clog2(hist_w);

    logic [hist_w-1:0]  history_q;
    logic [shift_w-1:0] chunk_shift;

    // newest bits enter at the top, older bits move toward bit 0
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            history_q <= '0;
        end else if (frame_end_i) begin
            history_q <= (history_q >> frame_bits) |
                         (hist_w'(rx_bits_i) << (hist_w - frame_bits));
        end
    end

    // chunk 0 is the top chunk_width bits
    assign chunk_shift = shift_w'(hist_w - chunk_width) -
                         shift_w'(chunk_width) * shift_w'(chunk_idx_i);
    assign chunk_o     = chunk_width'(history_q >> chunk_shift);

endmodule

/* hdl/chan_pkg.sv */
// channel step-response tables and the configuration port that fills them
package chan_pkg;

    localparam int coef_width = 8;
    localparam int tbl_addr_width = 10;    // sized for the largest table

    // one signed step-response contribution
    typedef logic signed [coef_width-1:0] coef_t;

    // write address, high to low: slice index, chunk index, chunk value
    typedef logic [tbl_addr_width-1:0] tbl_addr_t;

    // configuration loader states
    typedef enum logic [1:0] {
        IDLE,     // waiting for req
        WRITE,    // single write strobe
        HOLD      // ack high until req drops
    } load_state_e;

endpackage

/* hdl/chunk_sequencer.sv */
`timescale 1ns/10ps

// frame counter that walks the history one chunk per cycle
module chunk_sequencer #(
    parameter int chunk_width = 4,
    parameter int num_chunks  = 4,
    parameter int num_slices  = 4,
    parameter int frame_bits  = 8
) (
    input  logic                          emu_clk,
    input  logic                          emu_rst,
    output logic [$clog2(num_chunks)-1:0] chunk_idx_o,
    output logic [$clog2(num_chunks)-1:0] chunk_valid_o,
    output logic                          sum_restart_o,
    output logic                          frame_end_o,
    output logic                          frame_valid_o,
    output logic                          clk_adc_o
);
    localparam int idx_w      = $clog2(num_chunks);
    localparam int cnt_w      = $clog2(num_chunks + 2);
    localparam int last_count = num_chunks + 1;

    // adc clock is low for half of the frame, starting at count 2
    localparam int clk_fall = 2;
    localparam int clk_rise = clk_fall + ((2 + num_chunks) / 2) - 1;

    logic [cnt_w-1:0] count_q;
    logic [cnt_w-1:0] count_next;
    logic             clk_adc_next;

    assign count_next = (count_q == cnt_w'(last_count)) ? '0 : count_q + 1'b1;

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            count_q <= '0;
        end else begin
            count_q <= count_next;
        end
    end

    // chunk k is presented while the counter is k
    assign chunk_idx_o   = (count_q < cnt_w'(num_chunks)) ? idx_w'(count_q) : '0;
    assign sum_restart_o = (count_q == cnt_w'(1));
    assign frame_end_o   = (count_q == cnt_w'(last_count));

    // decode from the next count so the registered clock lines up with the counter
    assign clk_adc_next = !((count_next >= cnt_w'(clk_fall)) &&
                            (count_next <= cnt_w'(clk_rise)));

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            chunk_valid_o <= '0;
            frame_valid_o <= 1'b0;
            clk_adc_o     <= 1'b1;    // counter 0 sits in the high phase
        end else begin
            chunk_valid_o <= chunk_idx_o;    // follows the registered table read
            frame_valid_o <= frame_end_o;
            clk_adc_o     <= clk_adc_next;
        end
    end

    count_in_range: assert property (
        @(posedge emu_clk) disable iff (emu_rst)
        count_q <= cnt_w'(last_count)
    ) else $error("frame counter out of range: %0d", count_q);

endmodule

/* hdl/emu_pkg.sv */
// emulated datapath types shared by the slices and the top level
package emu_pkg;

    // slice accumulator, wide enough for the largest table sum plus margin
    localparam int acc_width = 12;

    // adc output magnitude
    localparam int mag_width = 8;

    // largest magnitude an adc slice can report
    localparam int mag_max = (1 << mag_width) - 1;

    typedef logic signed [acc_width-1:0] acc_t;    // signed running sum of one slice
    typedef logic [mag_width-1:0] mag_t;           // saturated absolute value

endpackage

/* hdl/step_table_loader.sv */
`timescale 1ns/10ps

// four-phase req/ack slave feeding the step-response tables
module step_table_loader import chan_pkg::*; #(
    parameter int chunk_width = 4,
    parameter int num_chunks  = 4,
    parameter int num_slices  = 4,
    parameter int frame_bits  = 8
) (
    input  logic      emu_clk,
    input  logic      emu_rst,
    input  logic      cfg_req_i,
    input  tbl_addr_t cfg_addr_i,
    input  coef_t     cfg_data_i,
    output logic      cfg_ack_o,
    output logic      tbl_we_o,
    output tbl_addr_t tbl_waddr_o,
    output coef_t     tbl_wdata_o
);
    // bits below the slice field address one entry of a slice table
    localparam int tab_aw = $clog2(num_chunks) + chunk_width;

    load_state_e state_q;

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:    if (cfg_req_i) state_q <= WRITE;
                WRITE:   state_q <= HOLD;
                HOLD:    if (!cfg_req_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // master holds address and data stable, capture once at req
    always_ff @(posedge emu_clk) begin
        if (state_q == IDLE && cfg_req_i) begin
            tbl_waddr_o <= cfg_addr_i;
            tbl_wdata_o <= cfg_data_i;
        end
    end

    assign tbl_we_o  = (state_q == WRITE);    // one strobe per transfer
    assign cfg_ack_o = (state_q == HOLD);

    ack_needs_req: assert property (
        @(posedge emu_clk) disable iff (emu_rst)
        $rose(cfg_ack_o) |-> cfg_req_i
    ) else $error("cfg ack raised without req");

    slice_in_range: assert property (
        @(posedge emu_clk) disable iff (emu_rst)
        (state_q == IDLE && cfg_req_i) |->
            (cfg_addr_i[$bits(tbl_addr_t)-1:tab_aw] < num_slices)
    ) else $error("cfg address selects a missing slice");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the analog_core testbench with Verilator and run it
# the result is taken from the simulation output, nothing is written to a log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module tb_analog_core \
    -o sim_analog_core \
    && ./obj_dir/sim_analog_core | tee /dev/stderr | grep "Testbench passed" > /dev/null \
    && echo "run_sim: simulation ok" \
    || { echo "run_sim: simulation did not pass"; exit 1; }

/* verif/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// reference model of the bit history, the step tables and the slice sums
// included inside the testbench module, uses its localparams

logic [31:0]       lfsr_state = 32'h6f5e2e5a;
int                model_tbl [num_slices][depth];    // copy of every slice table
logic [hist_w-1:0] model_hist;

// fibonacci lfsr, taps 32 22 2 1, one step per bit
function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_step()};
    end
    return v;
endfunction

// new frame bits land at the top, older bits move down by frame_bits
function automatic void model_shift(input logic [frame_bits-1:0] bits);
    logic [hist_w-1:0] shifted;
    for (int i = 0; i < hist_w; i++) begin
        if (i >= hist_w - frame_bits) begin
            shifted[i] = bits[i - (hist_w - frame_bits)];
        end else begin
            shifted[i] = model_hist[i + frame_bits];
        end
    end
    model_hist = shifted;
endfunction

// chunk k starts k*chunk_width bits below the top, msb first
function automatic int model_sum(input int slice);
    int sum;
    int value;
    sum = 0;
    for (int k = 0; k < num_chunks; k++) begin
        value = 0;
        for (int b = 0; b < chunk_width; b++) begin
            value = value * 2 + int'(model_hist[hist_w - 1 - k * chunk_width - b]);
        end
        sum += model_tbl[slice][k * (1 << chunk_width) + value];
    end
    return sum;
endfunction

`endif

/* verif/tb_analog_core.sv */
`timescale 1ns/10ps

// testbench for the emulated receiver front end
module tb_analog_core;

    localparam int chunk_width = 4;
    localparam int num_chunks  = 4;
    localparam int num_slices  = 4;
    localparam int frame_bits  = 8;
    localparam int hist_w      = num_chunks * chunk_width;
    localparam int depth       = num_chunks << chunk_width;    // entries per slice table
    localparam int frame_len   = num_chunks + 2;
    localparam int adc_low     = (2 + num_chunks) / 2;
    localparam int max_xfer    = 10;

    localparam int zero_frames   = 8;
    localparam int conv_frames   = 40;
    localparam int sat_frames    = 6;
    localparam int timing_frames = 8;
    localparam int num_xfers     = 1 + num_slices * depth + 2 * depth;
    localparam int num_frames    = zero_frames + conv_frames + sat_frames + timing_frames + 4;
    localparam int wd_cycles     = num_xfers * 10 + num_frames * frame_len + 20;

    logic                       emu_clk;
    logic                       emu_rst;
    logic [frame_bits-1:0]      rx_bits;
    logic                       cfg_req;
    logic [9:0]                 cfg_addr;
    logic [7:0]                 cfg_data;
    logic                       cfg_ack;
    logic                       frame_valid;
    logic                       clk_adc;
    logic [num_slices-1:0]      adc_sgn;
    logic [num_slices-1:0][7:0] adc_mag;

    int errors;
    int checks;
    int tests_run;
    int tests_failed;

    `include "tb_model.svh"

    analog_core #(
        .chunk_width (chunk_width),
        .num_chunks  (num_chunks),
        .num_slices  (num_slices),
        .frame_bits  (frame_bits)
    ) u_dut (
        .emu_clk       (emu_clk),
        .emu_rst       (emu_rst),
        .rx_bits_i     (rx_bits),
        .cfg_req_i     (cfg_req),
        .cfg_addr_i    (cfg_addr),
        .cfg_data_i    (cfg_data),
        .cfg_ack_o     (cfg_ack),
        .frame_valid_o (frame_valid),
        .clk_adc_o     (clk_adc),
        .adc_sgn_o     (adc_sgn),
        .adc_mag_o     (adc_mag)
    );

    initial begin
        emu_clk = 1'b0;
        forever #20 emu_clk = ~emu_clk;
    end

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
            $display("%s: FAILED, %0d errors", name, errors - err_before);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    // one four-phase write, started at count 0 so the strobe lands mid frame
    task automatic cfg_write(input string name, input int slice, input int entry,
                             input int coef);
        int waited;
        @(negedge emu_clk);
        while (!frame_valid) @(negedge emu_clk);
        @(posedge emu_clk);
        cfg_addr <= 10'(slice * depth + entry);    // slice, chunk index, chunk value
        cfg_data <= 8'(coef);
        cfg_req  <= 1'b1;
        @(negedge emu_clk);
        waited = 1;
        if (cfg_ack) begin
            errors++;
            $display("%s: ack already high when req was raised", name);
        end
        while (!cfg_ack && waited < max_xfer) begin
            @(negedge emu_clk);
            waited++;
        end
        if (!cfg_ack) begin
            errors++;
            $display("%s: handshake hung, no ack within %0d cycles", name, max_xfer);
        end
        @(posedge emu_clk);
        cfg_req <= 1'b0;
        @(negedge emu_clk);
        waited++;
        while (cfg_ack && waited < max_xfer) begin
            @(negedge emu_clk);
            waited++;
        end
        if (cfg_ack) begin
            errors++;
            $display("%s: handshake hung, ack still high after req dropped", name);
        end
        model_tbl[slice][entry] = coef;
    endtask

    // kind 0 expects zero sums, kind 1 the model, kind 2 saturated slices 0 and 1
    task automatic run_frames(input string name, input int n, input int kind);
        int               exp_sum [64][num_slices];
        int               e_mag;
        int               sum;
        logic             e_sgn;
        logic             have;
        logic [frame_bits-1:0] v;
        model_hist = '0;
        for (int j = 0; j < n; j++) begin
            @(negedge emu_clk);
            while (!frame_valid) @(negedge emu_clk);
            for (int s = 0; s < num_slices; s++) begin
                have  = 1'b0;
                e_mag = 0;
                e_sgn = 1'b1;
                if (kind == 0) begin
                    have = 1'b1;
                end else if (kind == 1 && j >= 3) begin
                    sum   = exp_sum[j - 2][s];    // bits driven two frames back
                    have  = 1'b1;
                    e_sgn = (sum >= 0);
                    e_mag = (sum < 0) ? -sum : sum;
                    if (e_mag > 255) e_mag = 255;
                end else if (kind == 2 && j >= 2 && s < 2) begin
                    have  = 1'b1;
                    e_mag = 255;
                    e_sgn = (s == 0);
                end
                if (have) begin
                    checks++;
                    if (adc_mag[s] != 8'(e_mag) || adc_sgn[s] != e_sgn) begin
                        errors++;
                        $display("ERROR %s frame %0d slice %0d: expected sgn %0d mag %0d, %s",
                                 name, j, s, e_sgn, e_mag,
                                 $sformatf("actual sgn %0d mag %0d", adc_sgn[s], adc_mag[s]));
                    end
                end
            end
            v = frame_bits'(rand_bits(frame_bits));
            @(posedge emu_clk);
            rx_bits <= v;    // sampled at the next frame end
            model_shift(v);
            for (int s = 0; s < num_slices; s++) begin
                exp_sum[j][s] = model_sum(s);
            end
        end
    endtask

    task automatic check_timing(input string name, input int n);
        int period;
        int low;
        @(negedge emu_clk);
        while (!frame_valid) @(negedge emu_clk);
        for (int j = 0; j < n; j++) begin
            period = 0;
            low    = 0;
            do begin
                @(negedge emu_clk);
                period++;
                if (!clk_adc) low++;
            end while (!frame_valid && period < 2 * frame_len);
            checks += 2;
            if (period != frame_len) begin
                errors++;
                $display("ERROR %s frame %0d period: expected %0d actual %0d",
                         name, j, frame_len, period);
            end
            if (low != adc_low) begin
                errors++;
                $display("ERROR %s frame %0d adc clock low: expected %0d actual %0d",
                         name, j, adc_low, low);
            end
        end
    endtask

    initial begin
        int               err_before;
        logic signed [7:0] c;
        emu_rst  = 1'b1;
        rx_bits  = '0;
        cfg_req  = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(posedge emu_clk);
        emu_rst <= 1'b0;

        err_before = errors;
        run_frames("zero_tables", zero_frames, 0);
        finish_test("zero_tables", err_before);

        err_before = errors;
        c = 8'(rand_bits(8));
        cfg_write("handshake", 0, 0, c);
        finish_test("handshake", err_before);

        err_before = errors;
        for (int s = 0; s < num_slices; s++) begin
            for (int e = 0; e < depth; e++) begin
                c = 8'(rand_bits(8));
                cfg_write("random_conv", s, e, c);
            end
        end
        run_frames("random_conv", conv_frames, 1);
        finish_test("random_conv", err_before);

        err_before = errors;
        for (int e = 0; e < depth; e++) begin
            cfg_write("saturation", 0, e, 127);
            cfg_write("saturation", 1, e, -128);
        end
        run_frames("saturation", sat_frames, 2);
        finish_test("saturation", err_before);

        err_before = errors;
        check_timing("frame_timing", timing_frames);
        finish_test("frame_timing", err_before);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog sized from the transfer and frame counts
    initial begin
        repeat (wd_cycles) @(posedge emu_clk);
        $display("timeout: run did not finish within %0d cycles", wd_cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule
